// ==== rtl/serial_pkg.sv ====
package serial_pkg;

  // clock cycles per serial bit, kept small for short simulations
  localparam int clks_per_bit = 8;

  // payload bits per frame
  localparam int data_bits = 8;

  // one payload byte
  typedef logic [data_bits-1:0] uart_byte_t;

  // counts data bits plus start and stop
  typedef logic [$clog2(data_bits + 2)-1:0] bit_cnt_t;

  // counts cycles within one bit
  typedef logic [$clog2(clks_per_bit + 1)-1:0] tick_cnt_t;

endpackage

// ==== rtl/stream_pkg.sv ====
package stream_pkg;

  // number of buffered bytes
  localparam int fifo_depth = 8;

  // read and write pointers wrap naturally
  typedef logic [$clog2(fifo_depth)-1:0] fifo_ptr_t;

  // one extra bit so that a full buffer is representable
  typedef logic [$clog2(fifo_depth):0] fifo_level_t;

endpackage

// ==== rtl/byte_stream_if.sv ====
`timescale 1ns/1ps

interface byte_stream_if (
  input logic cpu_clk_g
);
  logic                   valid;
  logic                   ready;
  serial_pkg::uart_byte_t data;

  // valid and data hold until a cycle with ready high
  modport producer (
    input  cpu_clk_g,
    input  ready,
    output valid,
    output data
  );

  modport consumer (
    input  cpu_clk_g,
    input  valid,
    input  data,
    output ready
  );

endinterface

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic            cpu_clk_g,
  input  logic            rst,
  input  logic            rx_line,
  byte_stream_if.producer out
);
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t              state_q;
  logic                   rx_meta;
  logic                   rx_sync;
  serial_pkg::tick_cnt_t  tick_q;
  serial_pkg::bit_cnt_t   bit_q;
  serial_pkg::uart_byte_t shift_q;
  logic                   valid_q;
  logic                   half_tick;
  logic                   full_tick;

  // line idles high, so the synchronizer comes out of reset high
  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_line;
      rx_sync <= rx_meta;
    end
  end

  assign half_tick = tick_q == serial_pkg::tick_cnt_t'(serial_pkg::clks_per_bit / 2 - 1);
  assign full_tick = tick_q == serial_pkg::tick_cnt_t'(serial_pkg::clks_per_bit - 1);

  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      state_q <= st_idle;
      tick_q  <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      if (valid_q && out.ready) begin
        valid_q <= 1'b0;
      end
      case (state_q)
        st_idle: begin
          tick_q <= '0;
          bit_q  <= '0;
          // no new frame while the last byte is still pending
          if (!valid_q && !rx_sync) begin
            state_q <= st_start;
          end
        end
        st_start: begin
          if (half_tick) begin
            tick_q  <= '0;
            state_q <= rx_sync ? st_idle : st_data;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        st_data: begin
          if (full_tick) begin
            tick_q <= '0;
            bit_q  <= bit_q + 1'b1;
            if (bit_q == serial_pkg::bit_cnt_t'(serial_pkg::data_bits - 1)) begin
              state_q <= st_stop;
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        st_stop: begin
          if (full_tick) begin
            tick_q  <= '0;
            state_q <= st_idle;
            // a low stop bit drops the frame
            if (rx_sync) begin
              valid_q <= 1'b1;
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // lsb first, so new bits enter at the top
  always_ff @(posedge cpu_clk_g) begin
    if (state_q == st_data && full_tick) begin
      shift_q <= {rx_sync, shift_q[serial_pkg::data_bits-1:1]};
    end
  end

  assign out.valid = valid_q;
  assign out.data  = shift_q;

endmodule

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo (
  input  logic            cpu_clk_g,
  input  logic            rst,
  byte_stream_if.consumer wr,
  byte_stream_if.producer rd
);
  serial_pkg::uart_byte_t  mem [stream_pkg::fifo_depth];
  stream_pkg::fifo_ptr_t   wr_ptr_q;
  stream_pkg::fifo_ptr_t   rd_ptr_q;
  stream_pkg::fifo_level_t level_q;
  logic                    full;
  logic                    push;
  logic                    pop;

  assign full = level_q == stream_pkg::fifo_level_t'(stream_pkg::fifo_depth);
  assign push = wr.valid && wr.ready;
  assign pop  = rd.valid && rd.ready;

  assign wr.ready = !full;
  assign rd.valid = level_q != '0;
  assign rd.data  = mem[rd_ptr_q];

  always_ff @(posedge cpu_clk_g) begin
    if (push) begin
      mem[wr_ptr_q] <= wr.data;
    end
  end

  // depth is a power of two, pointers wrap on overflow
  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic            cpu_clk_g,
  input  logic            rst,
  input  logic            stall,
  byte_stream_if.consumer in,
  output logic            tx_line
);
  logic                                busy_q;
  logic [serial_pkg::data_bits+1:0]    frame_q;
  serial_pkg::tick_cnt_t               tick_q;
  serial_pkg::bit_cnt_t                bit_q;
  logic                                take;
  logic                                full_tick;

  // new bytes only in idle, non-stalled cycles
  assign in.ready  = !busy_q && !stall;
  assign take      = in.valid && in.ready;
  assign full_tick = tick_q == serial_pkg::tick_cnt_t'(serial_pkg::clks_per_bit - 1);

  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      busy_q <= 1'b0;
      tick_q <= '0;
      bit_q  <= '0;
    end else if (!busy_q) begin
      tick_q <= '0;
      bit_q  <= '0;
      if (take) begin
        busy_q <= 1'b1;
      end
    end else if (full_tick) begin
      tick_q <= '0;
      // last bit is the stop bit
      if (bit_q == serial_pkg::bit_cnt_t'(serial_pkg::data_bits + 1)) begin
        busy_q <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      tick_q <= tick_q + 1'b1;
    end
  end

  // stop, data and start bit loaded together, shifted out lsb first
  always_ff @(posedge cpu_clk_g) begin
    if (take) begin
      frame_q <= {1'b1, in.data, 1'b0};
    end else if (busy_q && full_tick) begin
      frame_q <= {1'b1, frame_q[serial_pkg::data_bits+1:1]};
    end
  end

  assign tx_line = busy_q ? frame_q[0] : 1'b1;

endmodule

// ==== rtl/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl (
  input  logic cpu_clk_g,
  input  logic rst,
  input  logic stall_sw,
  output logic stall,
  output logic stall_mode
);
  logic sw_meta;
  logic sw_sync;
  logic sw_prev;
  logic sw_rise;

  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      sw_meta <= 1'b0;
      sw_sync <= 1'b0;
      sw_prev <= 1'b0;
    end else begin
      sw_meta <= stall_sw;
      sw_sync <= sw_meta;
      sw_prev <= sw_sync;
    end
  end

  // one toggle per press, however long the switch is held
  assign sw_rise = sw_sync && !sw_prev;

  always_ff @(posedge cpu_clk_g) begin
    if (rst) begin
      stall_mode <= 1'b0;
      stall      <= 1'b0;
    end else begin
      if (sw_rise) begin
        stall_mode <= !stall_mode;
      end
      stall <= stall_mode ? !stall : 1'b0;
    end
  end

endmodule

// ==== rtl/serial_echo_top.sv ====
`timescale 1ns/1ps

module serial_echo_top (
  input  logic cpu_clk_g,
  input  logic rst,
  input  logic serial_rx,
  output logic serial_tx,
  input  logic stall_sw,
  output logic stall_led
);
  logic stall;
  logic stall_mode;

  byte_stream_if rx_stream (.cpu_clk_g(cpu_clk_g));
  byte_stream_if tx_stream (.cpu_clk_g(cpu_clk_g));

  uart_rx u_rx (
    .cpu_clk_g (cpu_clk_g),
    .rst       (rst),
    .rx_line   (serial_rx),
    .out       (rx_stream.producer)
  );

  // buffers received bytes until the transmitter is free
  byte_fifo u_fifo (
    .cpu_clk_g (cpu_clk_g),
    .rst       (rst),
    .wr        (rx_stream.consumer),
    .rd        (tx_stream.producer)
  );

  uart_tx u_tx (
    .cpu_clk_g (cpu_clk_g),
    .rst       (rst),
    .stall     (stall),
    .in        (tx_stream.consumer),
    .tx_line   (serial_tx)
  );

  stall_ctrl u_stall (
    .cpu_clk_g  (cpu_clk_g),
    .rst        (rst),
    .stall_sw   (stall_sw),
    .stall      (stall),
    .stall_mode (stall_mode)
  );

  assign stall_led = stall_mode;

endmodule

// ==== tests/serial_echo_chk.sv ====
`timescale 1ns/1ps

module serial_echo_chk (
  input logic                    cpu_clk_g,
  input logic                    rst,
  input logic                    wr_valid,
  input logic                    wr_ready,
  input serial_pkg::uart_byte_t  wr_data,
  input logic                    rd_valid,
  input logic                    rd_ready,
  input serial_pkg::uart_byte_t  rd_data,
  input stream_pkg::fifo_level_t level,
  input logic                    full,
  input stream_pkg::fifo_ptr_t   wr_ptr
);
  // read back by the testbench at the end of the run
  int unsigned fire_cnt = 0;

  wr_valid_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
    wr_valid && !wr_ready |=> wr_valid)
    else begin
      fire_cnt++;
      $error("rx_stream valid dropped before ready");
    end

  rd_valid_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
    rd_valid && !rd_ready |=> rd_valid)
    else begin
      fire_cnt++;
      $error("tx_stream valid dropped before ready");
    end

  wr_data_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
    wr_valid && !wr_ready |=> $stable(wr_data))
    else begin
      fire_cnt++;
      $error("rx_stream data changed while waiting");
    end

  rd_data_hold: assert property (@(posedge cpu_clk_g) disable iff (rst)
    rd_valid && !rd_ready |=> $stable(rd_data))
    else begin
      fire_cnt++;
      $error("tx_stream data changed while waiting");
    end

  level_bound: assert property (@(posedge cpu_clk_g) disable iff (rst)
    level <= stream_pkg::fifo_level_t'(stream_pkg::fifo_depth))
    else begin
      fire_cnt++;
      $error("fifo level above depth");
    end

  // a full buffer must not move its write pointer
  no_write_full: assert property (@(posedge cpu_clk_g) disable iff (rst)
    full |=> $stable(wr_ptr))
    else begin
      fire_cnt++;
      $error("fifo accepted a write while full");
    end

endmodule

bind byte_fifo serial_echo_chk u_chk (
  .cpu_clk_g (cpu_clk_g),
  .rst       (rst),
  .wr_valid  (wr.valid),
  .wr_ready  (wr.ready),
  .wr_data   (wr.data),
  .rd_valid  (rd.valid),
  .rd_ready  (rd.ready),
  .rd_data   (rd.data),
  .level     (level_q),
  .full      (full),
  .wr_ptr    (wr_ptr_q)
);

// ==== tests/serial_echo_tb.sv ====
`timescale 1ns/1ps

module serial_echo_tb;
  localparam int clk_half_ns  = 2;
  localparam int n_rows       = 12;
  localparam int frame_cycles = (serial_pkg::data_bits + 2) * serial_pkg::clks_per_bit;
  localparam int timeout_ns   = (n_rows * 2 * frame_cycles + 4 * frame_cycles) * 2 * clk_half_ns;

  typedef struct packed {
    serial_pkg::uart_byte_t data;
    logic                   bad_stop;
    logic                   press;
    logic                   exp_echo;
    logic                   exp_led;
  } row_t;

  logic cpu_clk_g;
  logic rst;
  logic serial_rx;
  logic serial_tx;
  logic stall_sw;
  logic stall_led;

  row_t                   rows [n_rows];
  serial_pkg::uart_byte_t exp_q [$];
  serial_pkg::uart_byte_t echo_q [$];
  int unsigned            lcg_state = 86;

  serial_echo_top uut (
    .cpu_clk_g (cpu_clk_g),
    .rst       (rst),
    .serial_rx (serial_rx),
    .serial_tx (serial_tx),
    .stall_sw  (stall_sw),
    .stall_led (stall_led)
  );

  always #(clk_half_ns) cpu_clk_g = ~cpu_clk_g;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits of the generator are the better mixed ones
  function automatic serial_pkg::uart_byte_t lcg_byte();
    return serial_pkg::uart_byte_t'(lcg_next() >> 24);
  endfunction

  task automatic fail_now();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_byte(input string name, input serial_pkg::uart_byte_t exp,
                            input serial_pkg::uart_byte_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %02h, got %02h", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_led(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cpu_clk_g);
    #1;
  endtask

  task automatic drive_bit(input logic value);
    serial_rx = value;
    wait_cycles(serial_pkg::clks_per_bit);
  endtask

  task automatic send_frame(input serial_pkg::uart_byte_t data, input logic bad_stop);
    drive_bit(1'b0);
    for (int b = 0; b < serial_pkg::data_bits; b++) begin
      drive_bit(data[b]);
    end
    drive_bit(!bad_stop);
    serial_rx = 1'b1;
  endtask

  task automatic press_switch();
    stall_sw = 1'b1;
    wait_cycles(4);
    stall_sw = 1'b0;
    wait_cycles(4);
  endtask

  // data, bad stop, press first, echo expected, led expected
  task automatic fill_table();
    rows[0]  = '{8'h00, 1'b0, 1'b0, 1'b1, 1'b0};
    rows[1]  = '{8'hff, 1'b0, 1'b0, 1'b1, 1'b0};
    rows[2]  = '{8'h55, 1'b0, 1'b0, 1'b1, 1'b0};
    rows[3]  = '{8'haa, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[4]  = '{8'haa, 1'b0, 1'b0, 1'b1, 1'b0};
    // first press turns stall mode on
    rows[5]  = '{lcg_byte(), 1'b0, 1'b1, 1'b1, 1'b1};
    rows[6]  = '{8'h55, 1'b0, 1'b0, 1'b1, 1'b1};
    rows[7]  = '{lcg_byte(), 1'b1, 1'b0, 1'b0, 1'b1};
    rows[8]  = '{8'hff, 1'b0, 1'b0, 1'b1, 1'b1};
    rows[9]  = '{8'h00, 1'b0, 1'b0, 1'b1, 1'b1};
    rows[10] = '{lcg_byte(), 1'b0, 1'b1, 1'b1, 1'b0};
    rows[11] = '{lcg_byte(), 1'b0, 1'b0, 1'b1, 1'b0};
  endtask

  initial begin : stimulus
    int gap;
    cpu_clk_g = 1'b0;
    rst       = 1'b1;
    serial_rx = 1'b1;
    stall_sw  = 1'b0;
    fill_table();
    for (int c = 0; c < 12; c++) begin
      @(posedge cpu_clk_g);
      #1;
      if (c == 3) begin
        rst = 1'b0;
      end
      check_led("serial_tx", 1'b1, serial_tx);
      check_led("stall_led", 1'b0, stall_led);
    end
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].press) begin
        press_switch();
      end
      send_frame(rows[i].data, rows[i].bad_stop);
      check_led("stall_led", rows[i].exp_led, stall_led);
      if (rows[i].exp_echo) begin
        exp_q.push_back(rows[i].data);
      end
      // back to back under stall, random idle time otherwise
      if (rows[i].exp_led) begin
        gap = 1;
      end else begin
        gap = serial_pkg::clks_per_bit + int'(lcg_next() >> 27);
      end
      // a low stop bit needs idle line before the next start
      if (rows[i].bad_stop) begin
        gap = gap + 2 * serial_pkg::clks_per_bit;
      end
      wait_cycles(gap);
    end
    while (echo_q.size() < exp_q.size()) begin
      @(posedge cpu_clk_g);
    end
    // catch any late extra echo
    wait_cycles(2 * frame_cycles);
    check_count("echo count", exp_q.size(), echo_q.size());
    foreach (exp_q[k]) begin
      check_byte("serial_tx byte", exp_q[k], echo_q[k]);
    end
    if (uut.u_fifo.u_chk.fire_cnt != 0) begin
      $display("error: %0d FIFO handshake assertions failed", uut.u_fifo.u_chk.fire_cnt);
      fail_now();
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

  // decodes serial_tx at mid-bit, sampled on the falling clock
  initial begin : line_monitor
    serial_pkg::uart_byte_t rx_byte;
    wait (rst === 1'b0);
    forever begin
      @(negedge serial_tx);
      repeat (serial_pkg::clks_per_bit / 2) @(negedge cpu_clk_g);
      if (serial_tx !== 1'b0) begin
        $display("error at %0t ns: start bit on serial_tx did not stay low", $time);
        fail_now();
      end
      for (int b = 0; b < serial_pkg::data_bits; b++) begin
        repeat (serial_pkg::clks_per_bit) @(negedge cpu_clk_g);
        rx_byte[b] = serial_tx;
      end
      repeat (serial_pkg::clks_per_bit) @(negedge cpu_clk_g);
      if (serial_tx !== 1'b1) begin
        $display("error at %0t ns: stop bit on serial_tx was not high", $time);
        fail_now();
      end
      echo_q.push_back(rx_byte);
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("error: echo never finished within %0d ns", timeout_ns);
    fail_now();
  end

endmodule

// ==== serial_echo_top.f ====
rtl/serial_pkg.sv
rtl/stream_pkg.sv
rtl/byte_stream_if.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/stall_ctrl.sv
rtl/serial_echo_top.sv
tests/serial_echo_chk.sv
tests/serial_echo_tb.sv

// ==== Makefile ====
# Verilator build and run for the serial echo testbench

VERILATOR ?= verilator
TOP       ?= serial_echo_tb
FILELIST  ?= serial_echo_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a listed source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$*

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
